/* song.hex */
// One note code per line in hex, 0 to C, for song addresses 0 to 7
4
4
5
7
7
5
4
2

/* all.f */
piano_pkg.sv
ctrl_if.sv
key_input.sv
song_rom.sv
tone_generator.sv
piano_datapath.sv
piano_control.sv
piano_trainer.sv
tb_piano_trainer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_piano_trainer -o sim_piano
./obj_dir/sim_piano > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tb_piano_trainer.sv */
// Testbench for the piano trainer with key stimulus, reference model, checks and timeout
module tb_piano_trainer import piano_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    // Far above the few thousand cycles that all tests take together
    localparam int MAX_CYCLES = 40000;
    localparam int RES_CONT = 0;
    localparam int RES_WON  = 1;
    localparam int RES_LOST = 2;

    logic  clock;
    logic  rst;
    keys_t keys;
    logic  enter;
    keys_t leds;
    logic  buzzer;
    addr_t round;
    logic  playing;
    logic  won;
    logic  lost;

    logic [3:0]  song_notes [SONG_LEN];
    string       chk_names [$];
    logic [31:0] chk_got [$];
    logic [31:0] chk_exp [$];
    integer      seed;
    int          errors = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          buzz_run = 0;
    int          buzz_len_last = 0;
    bit          buzz_measured = 0;

    piano_trainer piano_trainer_i (
        .clock   (clock),
        .rst     (rst),
        .keys    (keys),
        .enter   (enter),
        .leds    (leds),
        .buzzer  (buzzer),
        .round   (round),
        .playing (playing),
        .won     (won),
        .lost    (lost)
    );

    always #(CLK_PERIOD / 2) clock = !clock;

    // Half periods grow by one cycle per key, starting at 2
    function automatic int tone_half(input int k);
        return k + 2;
    endfunction

    // Game rules for one press at the given round and address
    function automatic void next_outcome(input int rnd, input int adr, input int key,
                                         input logic [3:0] song [SONG_LEN],
                                         output int nrnd, output int nadr, output int res);
        nrnd = rnd;
        nadr = adr;
        res  = RES_CONT;
        if (key != int'(song[adr])) begin
            res = RES_LOST;
        end else if (adr == rnd) begin
            if (rnd == SONG_LEN - 1) begin
                res = RES_WON;
            end else begin
                nrnd = rnd + 1;
                nadr = 0;
            end
        end else begin
            nadr = adr + 1;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                     $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        chk_names.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(expected);
    endtask

    // Queued comparisons are done between clock edges
    always @(negedge clock) begin
        while (chk_names.size() > 0) begin
            check(chk_names.pop_front(), chk_got.pop_front(), chk_exp.pop_front());
        end
    end

    // Length of the first buzzer high phase while an LED is lit
    always @(negedge clock) begin
        if (leds == '0) begin
            buzz_run      = 0;
            buzz_measured = 0;
        end else if (!buzz_measured) begin
            if (buzzer) begin
                buzz_run++;
            end else if (buzz_run != 0) begin
                buzz_len_last = buzz_run;
                buzz_measured = 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic start_game();
        enter = 1'b1;
        repeat (3 * DEBOUNCE_CYCLES) next_cycle();
        enter = 1'b0;
        repeat (2 * DEBOUNCE_CYCLES + 2) next_cycle();
    endtask

    // Hold a key, catch the LED it lights, then let feedback finish
    task automatic press(input int k, output keys_t lit, output int buzz_len);
        int wait_cnt;
        buzz_len_last = 0;
        keys[k] = 1'b1;
        repeat (3 * DEBOUNCE_CYCLES) next_cycle();
        wait_cnt = 0;
        while (leds == '0 && wait_cnt < 60) begin
            next_cycle();
            wait_cnt++;
        end
        lit = leds;
        wait_cnt = 0;
        while (leds != '0 && wait_cnt < 4 * FEEDBACK_CYCLES) begin
            next_cycle();
            wait_cnt++;
        end
        keys = '0;
        repeat (2 * DEBOUNCE_CYCLES + 2) next_cycle();
        buzz_len = buzz_len_last;
    endtask

    task automatic play(input int rounds, input bit check_tone);
        int    rnd;
        int    adr;
        int    nrnd;
        int    nadr;
        int    res;
        int    key;
        int    blen;
        keys_t lit;
        rnd = 0;
        adr = 0;
        res = RES_CONT;
        while (res == RES_CONT && rnd < rounds) begin
            key = song_notes[adr];
            press(key, lit, blen);
            next_outcome(rnd, adr, key, song_notes, nrnd, nadr, res);
            expect_value("leds", lit, 1 << key);
            if (check_tone) expect_value("buzzer high cycles", blen, tone_half(key));
            expect_value("round", round, nrnd);
            expect_value("won", won, res == RES_WON);
            expect_value("lost", lost, 0);
            rnd = nrnd;
            adr = nadr;
        end
        if (rounds == SONG_LEN) expect_value("playing", playing, 0);
    endtask

    task automatic end_test(input string name);
        next_cycle();
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name,
                     errors - errors_before);
            tests_failed++;
        end
        errors_before = errors;
    endtask

    initial begin
        keys_t lit;
        keys_t seen;
        int    wrong;
        int    blen;
        int    nrnd;
        int    nadr;
        int    res;
        clock = 1'b0;
        rst   = 1'b1;
        keys  = '0;
        enter = 1'b0;
        seed  = 94727;
        $readmemh("song.hex", song_notes);
        repeat (5) @(posedge clock);
        #1 rst = 1'b0;

        expect_value("leds", leds, 0);
        expect_value("buzzer", buzzer, 0);
        expect_value("won", won, 0);
        expect_value("lost", lost, 0);
        expect_value("playing", playing, 0);
        start_game();
        expect_value("playing", playing, 1);
        expect_value("round", round, 0);
        end_test("reset and start");

        play(SONG_LEN, 1'b0);
        end_test("full game");

        // Wrong key in round 1, so the restart has a round to clear
        start_game();
        play(1, 1'b0);
        wrong = $unsigned($random(seed)) % NUM_KEYS;
        if (wrong == song_notes[0]) wrong = (wrong + 1) % NUM_KEYS;
        press(wrong, lit, blen);
        next_outcome(1, 0, wrong, song_notes, nrnd, nadr, res);
        expect_value("leds", lit, 0);
        expect_value("lost", lost, res == RES_LOST);
        expect_value("round", round, nrnd);
        expect_value("playing", playing, 0);
        start_game();
        expect_value("round", round, 0);
        expect_value("playing", playing, 1);
        expect_value("lost", lost, 0);
        end_test("wrong key");

        repeat (TIMEOUT_CYCLES + 10) next_cycle();
        expect_value("lost", lost, 1);
        expect_value("playing", playing, 0);
        end_test("press timeout");

        start_game();
        keys[song_notes[0]] = 1'b1;
        repeat (DEBOUNCE_CYCLES - 2) next_cycle();
        keys = '0;
        seen = '0;
        repeat (3 * DEBOUNCE_CYCLES) begin
            next_cycle();
            seen = seen | leds;
        end
        expect_value("leds", seen, 0);
        expect_value("round", round, 0);
        expect_value("lost", lost, 0);
        end_test("key glitch");

        play(3, 1'b1);
        end_test("buzzer period");

        $display("Tests: %0d run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* piano_trainer.sv */
// Top level of the piano trainer game, keys to LEDs and buzzer
module piano_trainer import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  keys_t keys,
    input  logic  enter,
    output keys_t leds,
    output logic  buzzer,
    output addr_t round,
    output logic  playing,
    output logic  won,
    output logic  lost
);

    logic  note_pulse;
    note_t note_code;
    logic  start_pulse;
    note_t shown_note;

    ctrl_if ctl_bus ();

    key_input key_input_i (
        .clock       (clock),
        .rst         (rst),
        .keys        (keys),
        .enter       (enter),
        .note_pulse  (note_pulse),
        .note_code   (note_code),
        .start_pulse (start_pulse)
    );

    piano_datapath piano_datapath_i (
        .clock      (clock),
        .rst        (rst),
        .ctl        (ctl_bus.dp),
        .note_pulse (note_pulse),
        .note_code  (note_code),
        .leds       (leds),
        .shown_note (shown_note),
        .round      (round)
    );

    piano_control piano_control_i (
        .clock       (clock),
        .rst         (rst),
        .ctl         (ctl_bus.ctrl),
        .start_pulse (start_pulse),
        .playing     (playing),
        .won         (won),
        .lost        (lost)
    );

    // Buzzer sounds whatever note is on the LEDs
    tone_generator tone_generator_i (
        .clock  (clock),
        .rst    (rst),
        .enable (shown_note != NO_NOTE),
        .note   (shown_note),
        .buzzer (buzzer)
    );

endmodule

/* piano_control.sv */
// Game FSM issuing the datapath strobes and the game status outputs
module piano_control import piano_pkg::*; (
    input  logic clock,
    input  logic rst,
    ctrl_if.ctrl ctl,
    input  logic start_pulse,
    output logic playing,
    output logic won,
    output logic lost
);

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Next state and strobes
    always_comb begin
        state_next         = state;
        ctl.clear_game     = 1'b0;
        ctl.store_note     = 1'b0;
        ctl.next_addr      = 1'b0;
        ctl.next_round     = 1'b0;
        ctl.start_feedback = 1'b0;
        ctl.start_timeout  = 1'b0;

        case (state)
            IDLE, WON, LOST: begin
                if (start_pulse) begin
                    ctl.clear_game    = 1'b1;
                    ctl.start_timeout = 1'b1;
                    state_next        = WAIT_KEY;
                end
            end
            WAIT_KEY: begin
                if (ctl.key_seen) begin
                    ctl.store_note = 1'b1;
                    state_next     = CHECK;
                end else if (ctl.timeout_done) begin
                    state_next = LOST;
                end
            end
            // Memory note and stored note are settled here
            CHECK: begin
                if (ctl.note_ok) begin
                    ctl.start_feedback = 1'b1;
                    state_next         = FEEDBACK;
                end else begin
                    state_next = LOST;
                end
            end
            FEEDBACK: begin
                if (ctl.feedback_done) state_next = NEXT;
            end
            NEXT: begin
                if (ctl.addr_is_round && ctl.last_round) begin
                    state_next = WON;
                end else begin
                    // End of round restarts from address 0
                    if (ctl.addr_is_round) begin
                        ctl.next_round = 1'b1;
                    end else begin
                        ctl.next_addr = 1'b1;
                    end
                    ctl.start_timeout = 1'b1;
                    state_next        = WAIT_KEY;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Status levels
    assign ctl.show_note = (state == FEEDBACK);
    assign won           = (state == WON);
    assign lost          = (state == LOST);
    assign playing       = !(state inside {IDLE, WON, LOST});

    // A won game sits on the last note of the last round
    a_won_at_last_note: assert property (@(posedge clock) disable iff (rst)
        won |-> ctl.last_round && ctl.addr_is_round);

endmodule

/* piano_datapath.sv */
// Note register, address and round counters, comparators, timers and LED decoder
module piano_datapath import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    ctrl_if.dp    ctl,
    input  logic  note_pulse,
    input  note_t note_code,
    output keys_t leds,
    output note_t shown_note,
    output addr_t round
);

    note_t  note_q;
    note_t  mem_note;
    addr_t  addr;
    timer_t fb_cnt;
    timer_t to_cnt;

    // Played note register
    always_ff @(posedge clock) begin
        if (ctl.clear_game) begin
            note_q <= '0;
        end else if (ctl.store_note) begin
            note_q <= note_code;
        end
    end

    // Address within the round and the round itself
    always_ff @(posedge clock) begin
        if (rst || ctl.clear_game) begin
            addr  <= '0;
            round <= '0;
        end else if (ctl.next_round) begin
            addr  <= '0;
            round <= round + addr_t'(1);
        end else if (ctl.next_addr) begin
            addr <= addr + addr_t'(1);
        end
    end

    song_rom song_rom_i (
        .clock (clock),
        .addr  (addr),
        .note  (mem_note)
    );

    // Feedback timer, loaded for FEEDBACK_CYCLES cycles of display
    always_ff @(posedge clock) begin
        if (rst) begin
            fb_cnt <= '0;
        end else if (ctl.start_feedback) begin
            fb_cnt <= timer_t'(FEEDBACK_CYCLES - 1);
        end else if (fb_cnt != '0) begin
            fb_cnt <= fb_cnt - timer_t'(1);
        end
    end

    // Timeout for the next press
    always_ff @(posedge clock) begin
        if (rst) begin
            to_cnt <= '0;
        end else if (ctl.start_timeout) begin
            to_cnt <= timer_t'(TIMEOUT_CYCLES - 1);
        end else if (to_cnt != '0) begin
            to_cnt <= to_cnt - timer_t'(1);
        end
    end

    // Conditions back to the FSM
    assign ctl.key_seen      = note_pulse;
    assign ctl.note_ok       = (note_q == mem_note);
    assign ctl.addr_is_round = (addr == round);
    assign ctl.last_round    = (round == addr_t'(SONG_LEN - 1));
    assign ctl.feedback_done = (fb_cnt == '0);
    assign ctl.timeout_done  = (to_cnt == '0);

    // One-hot LED of the note being shown
    assign shown_note = ctl.show_note ? note_q : NO_NOTE;
    assign leds = (shown_note < note_t'(NUM_KEYS)) ? (keys_t'(1) << shown_note) : '0;

    a_addr_within_round: assert property (@(posedge clock) disable iff (rst)
        addr <= round);

endmodule

/* tone_generator.sv */
// Square-wave buzzer with a half period looked up from the note code
module tone_generator import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  enable,
    input  note_t note,
    output logic  buzzer
);

    timer_t half_cnt;
    logic   active;

    assign active = enable && (note < note_t'(NUM_KEYS));

    // First active cycle raises the buzzer, then it toggles every half period
    always_ff @(posedge clock) begin
        if (rst || !active) begin
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (half_cnt == '0) begin
            half_cnt <= TONE_HALF[note] - timer_t'(1);
            buzzer   <= !buzzer;
        end else begin
            half_cnt <= half_cnt - timer_t'(1);
        end
    end

endmodule

/* song_rom.sv */
// Song note memory with registered read, loaded from song.hex
module song_rom import piano_pkg::*; (
    input  logic  clock,
    input  addr_t addr,
    output note_t note
);

    note_t mem [SONG_LEN];

    initial begin
        $readmemh("song.hex", mem);
    end

    // Data follows the address one cycle later
    always_ff @(posedge clock) begin
        note <= mem[addr];
    end

    // Every stored note must name a real key
    a_note_in_range: assert property (@(posedge clock)
        !$isunknown(note) |-> note <= note_t'(NUM_KEYS - 1));

endmodule

/* key_input.sv */
// Key debouncers, press and enter edge detection, note priority encoder
module key_input import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  keys_t keys,
    input  logic  enter,
    output logic  note_pulse,
    output note_t note_code,
    output logic  start_pulse
);

    // Bit NUM_KEYS is the enter key
    logic [NUM_KEYS:0] raw_q;
    logic [NUM_KEYS:0] stable;
    logic              any_q;
    logic              enter_q;
    note_t             code_next;

    // Input sampling register
    always_ff @(posedge clock) begin
        if (rst) begin
            raw_q <= '0;
        end else begin
            raw_q <= {enter, keys};
        end
    end

    // A level is taken after DEBOUNCE_CYCLES equal samples
    for (genvar i = 0; i <= NUM_KEYS; i++) begin : g_debounce
        db_count_t cnt;
        logic      level;

        always_ff @(posedge clock) begin
            if (rst) begin
                cnt   <= '0;
                level <= 1'b0;
            end else if (raw_q[i] == level) begin
                cnt <= '0;
            end else if (cnt == db_count_t'(DEBOUNCE_CYCLES - 1)) begin
                cnt   <= '0;
                level <= raw_q[i];
            end else begin
                cnt <= cnt + db_count_t'(1);
            end
        end

        assign stable[i] = level;
    end

    // Lowest pressed key wins
    always_comb begin
        code_next = NO_NOTE;
        for (int k = NUM_KEYS - 1; k >= 0; k--) begin
            if (stable[k]) code_next = note_t'(k);
        end
    end

    // Rising edges of the OR of note keys and of enter
    always_ff @(posedge clock) begin
        if (rst) begin
            any_q       <= 1'b0;
            enter_q     <= 1'b0;
            note_pulse  <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            any_q       <= |stable[NUM_KEYS-1:0];
            enter_q     <= stable[NUM_KEYS];
            note_pulse  <= (|stable[NUM_KEYS-1:0]) && !any_q;
            start_pulse <= stable[NUM_KEYS] && !enter_q;
        end
    end

    // Code registered together with the pulse
    always_ff @(posedge clock) begin
        note_code <= code_next;
    end

    a_pulse_has_note: assert property (@(posedge clock) disable iff (rst)
        note_pulse |-> note_code != NO_NOTE);

endmodule

/* ctrl_if.sv */
// Control strobes and condition flags between the game FSM and the datapath
interface ctrl_if;

    // Strobes from the FSM, one cycle wide
    logic clear_game;
    logic store_note;
    logic next_addr;
    logic next_round;
    logic start_feedback;
    logic start_timeout;

    // Enables LEDs and buzzer
    logic show_note;

    // Conditions from the datapath
    logic key_seen;
    logic note_ok;
    logic addr_is_round;
    logic last_round;
    logic feedback_done;
    logic timeout_done;

    modport ctrl (
        output clear_game, store_note, next_addr, next_round,
        output start_feedback, start_timeout, show_note,
        input  key_seen, note_ok, addr_is_round, last_round,
        input  feedback_done, timeout_done
    );

    modport dp (
        input  clear_game, store_note, next_addr, next_round,
        input  start_feedback, start_timeout, show_note,
        output key_seen, note_ok, addr_is_round, last_round,
        output feedback_done, timeout_done
    );

endinterface

/* piano_pkg.sv */
// Widths, typedefs, game FSM states, timer lengths and buzzer tone table
package piano_pkg;

    // Keyboard and note coding
    localparam int NUM_KEYS = 13;

    typedef logic [3:0] note_t;
    typedef logic [NUM_KEYS-1:0] keys_t;

    // Code used when no key is pressed or shown
    localparam note_t NO_NOTE = 4'd15;

    // Song memory
    localparam int SONG_LEN = 8;

    typedef logic [2:0] addr_t;

    // Timer lengths in clock cycles, scaled down for simulation
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int FEEDBACK_CYCLES = 16;
    localparam int TIMEOUT_CYCLES  = 300;

    typedef logic [8:0] timer_t;
    typedef logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] db_count_t;

    // Buzzer half periods in cycles, lowest note has the shortest period
    localparam timer_t TONE_HALF [NUM_KEYS] = '{
        2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14
    };

    // Game FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_KEY,
        CHECK,
        FEEDBACK,
        NEXT,
        WON,
        LOST
    } game_state_t;

endpackage
